// ==== Makefile ====
# Verilator lint, simulation and clean for the dcache project

VERILATOR ?= verilator
TOP       ?= tb_dcache
RTL_TOP   ?= dcache_top
FILELIST  ?= verilog.f
RTL_SRCS  ?= dcache_pkg.sv dcache_array.sv dcache_ctrl.sv dcache_top.sv
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "All tests passed" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dcache_array.sv ====
// dcache storage array with two-way tag compare, word select and line updates
`default_nettype none
`timescale 1ns/1ns

module dcache_array
	import dcache_pkg::*;
(
	input  logic         clk,
	input  logic         proc_reset,
	input  word_addr_t   proc_addr,
	input  logic         proc_write,
	input  word_t        proc_wdata,
	input  cache_state_e state,
	input  logic         do_fill,
	input  logic         do_clean,
	input  cache_line_u  mem_rdata,
	output logic         hit,
	output word_t        proc_rdata,
	output logic         victim_dirty,
	output line_addr_t   victim_addr,
	output cache_line_u  victim_line
);

	addr_fields_t        fields;
	way_entry_t          entries [num_ways][num_sets];
	logic [num_sets-1:0] repl;        // way to replace next, one bit per set
	logic [num_ways-1:0] hit_vec;
	logic                hit_way;
	logic                vic_way;
	way_entry_t          hit_entry;
	way_entry_t          vic_entry;
	logic                write_hit;

	assign fields = proc_addr;

	// ---------------------------------------------------------------------------
	// lookup
	// ---------------------------------------------------------------------------
	always_comb begin
		for (int w = 0; w < num_ways; w++) begin
			hit_vec[w] = entries[w][fields.set].valid &&
				(entries[w][fields.set].tag == fields.tag);
		end
	end

	assign hit       = |hit_vec;
	assign hit_way   = hit_vec[1];    // way 0 unless way 1 matches
	assign hit_entry = entries[hit_way][fields.set];

	// word view of the hit line
	assign proc_rdata = hit ? hit_entry.data.words[fields.off] : '0;

	// victim is whatever the replace bit points at
	assign vic_way      = repl[fields.set];
	assign vic_entry    = entries[vic_way][fields.set];
	assign victim_dirty = vic_entry.valid && vic_entry.dirty;
	assign victim_addr  = {vic_entry.tag, fields.set};
	assign victim_line  = vic_entry.data;

	// write hits need no help from the controller
	assign write_hit = (state == compare_tag) && proc_write && hit;

	// ---------------------------------------------------------------------------
	// updates
	// ---------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			repl <= '0;
			for (int w = 0; w < num_ways; w++) begin
				for (int s = 0; s < num_sets; s++) begin
					entries[w][s].valid <= 1'b0;
					entries[w][s].dirty <= 1'b0;
				end
			end
		end else begin
			if (write_hit) begin
				entries[hit_way][fields.set].data.words[fields.off] <= proc_wdata;
				entries[hit_way][fields.set].dirty <= 1'b1;
			end

			if (do_clean) begin
				entries[vic_way][fields.set].dirty <= 1'b0;    // line is now in memory
			end

			// whole line arrives at once
			if (do_fill) begin
				entries[vic_way][fields.set].valid <= 1'b1;
				entries[vic_way][fields.set].dirty <= 1'b0;
				entries[vic_way][fields.set].tag   <= fields.tag;
				entries[vic_way][fields.set].data  <= mem_rdata;
				repl[fields.set]                   <= ~vic_way;
			end
		end
	end

	// a tag lives in at most one way of a set
	assert property (@(posedge clk) disable iff (proc_reset)
		!(hit_vec[0] && hit_vec[1]));

	// the address is held through a miss, so the filled line hits next cycle
	assert property (@(posedge clk) disable iff (proc_reset)
		do_fill |=> hit);

endmodule

`default_nettype wire

// ==== dcache_cases.txt ====
# op addr wdata rdata wb_line, all hex except op (r or w) and wb_line none
# rdata is checked on reads only, wb_line is the line that must be written back
r 00000010 00000000 5a5a0010 none
r 00000013 00000000 5a5a0013 none
w 00000011 deadbeef 00000000 none
r 00000011 00000000 deadbeef none
r 00000020 00000000 5a5a0020 none
r 00000030 00000000 5a5a0030 00000004
r 00000011 00000000 deadbeef none
r 00000012 00000000 5a5a0012 none
r 00000010 00000000 5a5a0010 none
w 00001234 11111111 00000000 none
w 00001235 22222222 00000000 none
w 00001236 33333333 00000000 none
w 00001237 44444444 00000000 none
r 00001236 00000000 33333333 none
r 00001234 00000000 11111111 none
r 00001237 00000000 44444444 none
r 00001235 00000000 22222222 none
r 00001244 00000000 5a5a1244 none
r 00001254 00000000 5a5a1254 0000048d
r 00001236 00000000 33333333 none
r 00001237 00000000 44444444 none
r 00001234 00000000 11111111 none
r 00001235 00000000 22222222 none
w 3ffffff9 cafef00d 00000000 none
r 3ffffff9 00000000 cafef00d none
r 3ffffffa 00000000 65a5fffa none
r 0000002b 00000000 5a5a002b none
w 0000002b 0badc0de 00000000 none
r 0000002b 00000000 0badc0de none
r 3ffffffb 00000000 65a5fffb none
r 0000004a 00000000 5a5a004a 0ffffffe
r 0000002b 00000000 0badc0de none
r 00000068 00000000 5a5a0068 0000000a
r 3ffffff9 00000000 cafef00d none

// ==== dcache_ctrl.sv ====
// dcache controller FSM for tag compare, write-back and allocate
`default_nettype none
`timescale 1ns/1ns

module dcache_ctrl
	import dcache_pkg::*;
(
	input  logic         clk,
	input  logic         proc_reset,
	input  logic         proc_read,
	input  logic         proc_write,
	input  logic         hit,
	input  logic         victim_dirty,
	input  logic         mem_ready,
	output cache_state_e state,
	output logic         proc_stall,
	output logic         mem_read,
	output logic         mem_write,
	output logic         do_fill,
	output logic         do_clean
);

	cache_state_e next_state;
	logic         req;
	logic         miss;

	assign req  = proc_read || proc_write;
	assign miss = req && !hit;

	// ---------------------------------------------------------------------------
	// state register
	// ---------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state <= compare_tag;
		end else begin
			state <= next_state;
		end
	end

	// ---------------------------------------------------------------------------
	// next state
	// ---------------------------------------------------------------------------
	always_comb begin
		next_state = state;
		case (state)
			compare_tag: begin
				if (miss) begin
					next_state = victim_dirty ? write_back : allocate;
				end
			end
			write_back: begin
				if (mem_ready) begin
					next_state = allocate;    // fetch the missing line next
				end
			end
			allocate: begin
				if (mem_ready) begin
					next_state = compare_tag;
				end
			end
			default: begin
				next_state = compare_tag;
			end
		endcase
	end

	// ---------------------------------------------------------------------------
	// outputs
	// ---------------------------------------------------------------------------

	// stall from the request cycle of a miss until the retry hits
	assign proc_stall = (state != compare_tag) || miss;

	// request level drops in the mem_ready cycle
	assign mem_write = (state == write_back) && !mem_ready;
	assign mem_read  = (state == allocate) && !mem_ready;

	// one-cycle strobes for the array update at the following edge
	assign do_clean = (state == write_back) && mem_ready;
	assign do_fill  = (state == allocate) && mem_ready;

	assert property (@(posedge clk) disable iff (proc_reset)
		!(mem_read && mem_write));

	assert property (@(posedge clk) disable iff (proc_reset)
		(state != compare_tag) |-> proc_stall);

endmodule

`default_nettype wire

// ==== dcache_pkg.sv ====
// dcache shared types covering cache geometry, address split, line and way layout
`default_nettype none

package dcache_pkg;

	// ---------------------------------------------------------------------------
	// geometry
	// ---------------------------------------------------------------------------
	localparam int num_sets = 4;
	localparam int num_ways = 2;

	typedef logic [31:0] word_t;
	typedef logic [29:0] word_addr_t;    // processor word address
	typedef logic [27:0] line_addr_t;    // tag then set index
	typedef logic [25:0] tag_t;
	typedef logic [1:0]  set_idx_t;
	typedef logic [1:0]  word_off_t;

	// word address split with the msb first
	typedef struct packed {
		tag_t      tag;
		set_idx_t  set;
		word_off_t off;
	} addr_fields_t;

	// ---------------------------------------------------------------------------
	// line and way layout
	// ---------------------------------------------------------------------------

	// line view for memory transfers, word view for processor accesses
	typedef union packed {
		logic [127:0]    line;
		word_t [3:0]     words;    // words[0] sits at bits 31:0
	} cache_line_u;

	typedef struct packed {
		logic        valid;
		logic        dirty;
		tag_t        tag;
		cache_line_u data;
	} way_entry_t;

	typedef enum logic [1:0] {
		compare_tag = 2'd0,
		write_back  = 2'd1,
		allocate    = 2'd2
	} cache_state_e;

	// outgoing memory request carrying one line per transfer
	typedef struct packed {
		logic        read;
		logic        write;
		line_addr_t  addr;
		cache_line_u data;
	} mem_req_t;

endpackage

`default_nettype wire

// ==== dcache_top.sv ====
// dcache top level joining the storage array and the controller to both ports
`default_nettype none
`timescale 1ns/1ns

module dcache_top
	import dcache_pkg::*;
(
	input  logic        clk,
	input  logic        proc_reset,
	// processor side
	input  logic        proc_read,
	input  logic        proc_write,
	input  word_addr_t  proc_addr,
	input  word_t       proc_wdata,
	output word_t       proc_rdata,
	output logic        proc_stall,
	// memory side
	output logic        mem_read,
	output logic        mem_write,
	output line_addr_t  mem_addr,
	output cache_line_u mem_wdata,
	input  cache_line_u mem_rdata,
	input  logic        mem_ready
);

	addr_fields_t fields;
	cache_state_e state;
	logic         hit;
	logic         victim_dirty;
	line_addr_t   victim_addr;
	cache_line_u  victim_line;
	logic         req_read;
	logic         req_write;
	logic         do_fill;
	logic         do_clean;
	mem_req_t     req;

	assign fields = proc_addr;

	dcache_array u_array (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.proc_addr    (proc_addr),
		.proc_write   (proc_write),
		.proc_wdata   (proc_wdata),
		.state        (state),
		.do_fill      (do_fill),
		.do_clean     (do_clean),
		.mem_rdata    (mem_rdata),
		.hit          (hit),
		.proc_rdata   (proc_rdata),
		.victim_dirty (victim_dirty),
		.victim_addr  (victim_addr),
		.victim_line  (victim_line)
	);

	dcache_ctrl u_ctrl (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.proc_read    (proc_read),
		.proc_write   (proc_write),
		.hit          (hit),
		.victim_dirty (victim_dirty),
		.mem_ready    (mem_ready),
		.state        (state),
		.proc_stall   (proc_stall),
		.mem_read     (req_read),
		.mem_write    (req_write),
		.do_fill      (do_fill),
		.do_clean     (do_clean)
	);

	// ---------------------------------------------------------------------------
	// memory request
	// ---------------------------------------------------------------------------
	always_comb begin
		req.read  = req_read;
		req.write = req_write;
		req.addr  = {fields.tag, fields.set};    // missing line
		req.data  = '0;
		if (state == write_back) begin
			req.addr = victim_addr;
			req.data = victim_line;
		end
	end

	assign mem_read  = req.read;
	assign mem_write = req.write;
	assign mem_addr  = req.addr;
	assign mem_wdata = req.data;

endmodule

`default_nettype wire

// ==== tb_dcache.sv ====
// dcache testbench that replays file based accesses against a slow memory model
`default_nettype none
`timescale 1ns/1ns

module tb_dcache
	import dcache_pkg::*;
();

	typedef struct packed {
		logic       is_write;
		word_addr_t addr;
		word_t      wdata;
		word_t      exp_rdata;
		logic       wb_expected;
		line_addr_t wb_addr;
	} access_case_t;

	localparam int half_period = 50;
	localparam int mem_latency = 3;

	logic        clk;
	logic        proc_reset;
	logic        proc_read;
	logic        proc_write;
	word_addr_t  proc_addr;
	word_t       proc_wdata;
	word_t       proc_rdata;
	logic        proc_stall;
	logic        mem_read;
	logic        mem_write;
	line_addr_t  mem_addr;
	cache_line_u mem_wdata;
	cache_line_u mem_rdata;
	logic        mem_ready;
	int          rd_count;
	int          wb_count;
	line_addr_t  wb_addr;

	access_case_t cases [$];
	int           errors = 0;
	int           checks = 0;
	int           cycles = 0;
	int           cycle_limit = 50;
	bit           cases_ok;

	// expected tag state that tracks which lines should be resident
	logic                model_valid [num_ways][num_sets];
	tag_t                model_tag [num_ways][num_sets];
	logic [num_sets-1:0] model_repl;

	dcache_top u_dut (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_read  (proc_read),
		.proc_write (proc_write),
		.proc_addr  (proc_addr),
		.proc_wdata (proc_wdata),
		.proc_rdata (proc_rdata),
		.proc_stall (proc_stall),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready)
	);

	tb_mem_model #(
		.latency (mem_latency)
	) u_mem (
		.clk        (clk),
		.proc_reset (proc_reset),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready),
		.rd_count   (rd_count),
		.wb_count   (wb_count),
		.wb_addr    (wb_addr)
	);

	initial clk = 1'b0;
	always #half_period clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout, the run did not finish within %0d clock cycles", cycles);
			$display("Some tests failed");
			$finish;
		end
	end

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------
	task automatic compare_word(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic compare_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s = %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic compare_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	// ------------------------------------------------------------------------
	// case file and expected residency
	// ------------------------------------------------------------------------
	task automatic read_cases(output bit ok);
		int           fd;
		int           n;
		string        text;
		string        op;
		string        wb_text;
		word_addr_t   a;
		word_t        wd;
		word_t        ex;
		line_addr_t   la;
		access_case_t c;
		ok = 1'b0;
		fd = $fopen("dcache_cases.txt", "r");
		if (fd == 0) begin
			$display("cannot open dcache_cases.txt for reading");
			return;
		end
		while (!$feof(fd)) begin
			text = "";
			if ($fgets(text, fd) != 0) begin
				n = $sscanf(text, "%s %h %h %h %s", op, a, wd, ex, wb_text);
				// comments and blanks fall out here
				if (n == 5 && (op == "r" || op == "w")) begin
					c = '0;
					c.is_write  = (op == "w");
					c.addr      = a;
					c.wdata     = wd;
					c.exp_rdata = ex;
					if (wb_text != "none") begin
						void'($sscanf(wb_text, "%h", la));
						c.wb_expected = 1'b1;
						c.wb_addr     = la;
					end
					cases.push_back(c);
				end
			end
		end
		$fclose(fd);
		ok = (cases.size() > 0);
		if (!ok) begin
			$display("dcache_cases.txt holds no usable access lines");
		end
	endtask

	task automatic clear_model();
		for (int w = 0; w < num_ways; w++) begin
			for (int s = 0; s < num_sets; s++) begin
				model_valid[w][s] = 1'b0;
				model_tag[w][s]   = '0;
			end
		end
		model_repl = '0;
	endtask

	// a miss fills the way named by the set's replace bit, which then flips
	task automatic update_model(input word_addr_t a, output logic was_hit);
		addr_fields_t f;
		logic         v;
		f       = a;
		was_hit = 1'b0;
		for (int w = 0; w < num_ways; w++) begin
			if (model_valid[w][f.set] && model_tag[w][f.set] == f.tag) begin
				was_hit = 1'b1;
			end
		end
		if (!was_hit) begin
			v                    = model_repl[f.set];
			model_valid[v][f.set] = 1'b1;
			model_tag[v][f.set]   = f.tag;
			model_repl[f.set]     = ~v;
		end
	endtask

	// ------------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------------
	task automatic check_idle();
		@(negedge clk);
		#10;
		compare_flag("proc_stall", proc_stall, 1'b0);
		compare_flag("mem_read", mem_read, 1'b0);
		compare_flag("mem_write", mem_write, 1'b0);
	endtask

	task automatic apply_access(input access_case_t c);
		logic exp_hit;
		int   rd_before;
		int   wb_before;
		update_model(c.addr, exp_hit);
		rd_before = rd_count;
		wb_before = wb_count;
		@(negedge clk);
		proc_read  = !c.is_write;
		proc_write = c.is_write;
		proc_addr  = c.addr;
		proc_wdata = c.wdata;
		#10;
		if (exp_hit) begin
			compare_flag("proc_stall", proc_stall, 1'b0);    // hits add no cycles
		end
		while (proc_stall) begin
			@(negedge clk);
			#10;
		end
		if (!c.is_write) begin
			compare_word("proc_rdata", proc_rdata, c.exp_rdata);
		end
		compare_count("memory line reads", rd_count - rd_before, exp_hit ? 0 : 1);
		@(negedge clk);
		proc_read  = 1'b0;
		proc_write = 1'b0;
		compare_count("write-backs", wb_count - wb_before, c.wb_expected ? 1 : 0);
		if (c.wb_expected) begin
			compare_word("write-back line address", {4'b0, wb_addr}, {4'b0, c.wb_addr});
		end
	endtask

	initial begin
		proc_reset = 1'b1;
		proc_read  = 1'b0;
		proc_write = 1'b0;
		proc_addr  = '0;
		proc_wdata = '0;
		clear_model();
		read_cases(cases_ok);
		if (!cases_ok) begin
			$display("Some tests failed");
			$finish;
		end else begin
			cycle_limit = cases.size() * 20 + 50;
			repeat (2) @(negedge clk);
			proc_reset = 1'b0;
			check_idle();
			foreach (cases[i]) begin
				apply_access(cases[i]);
			end
			$display("dcache run done: %0d cases, %0d checks, %0d errors",
				cases.size(), checks, errors);
			if (errors == 0) begin
				$display("All tests passed");
			end else begin
				$display("Some tests failed");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== tb_mem_model.sv ====
// slow line memory model for the dcache testbench with fixed latency and a write-back log
`default_nettype none
`timescale 1ns/1ns

module tb_mem_model
	import dcache_pkg::*;
#(
	parameter int latency = 3
) (
	input  logic        clk,
	input  logic        proc_reset,
	input  logic        mem_read,
	input  logic        mem_write,
	input  line_addr_t  mem_addr,
	input  cache_line_u mem_wdata,
	output cache_line_u mem_rdata,
	output logic        mem_ready,
	output int          rd_count,
	output int          wb_count,
	output line_addr_t  wb_addr
);

	cache_line_u store [line_addr_t];    // only lines written back live here
	int          wait_cnt;

	// untouched words hold their word address xor a fixed mask
	function automatic cache_line_u fill_pattern(input line_addr_t la);
		cache_line_u l;
		for (int i = 0; i < 4; i++) begin
			l.words[i] = {2'b00, la, 2'(i)} ^ 32'h5a5a_0000;
		end
		return l;
	endfunction

	initial begin
		mem_ready = 1'b0;
		mem_rdata = '0;
	end

	always @(posedge clk) begin
		if (proc_reset) begin
			mem_ready <= 1'b0;
			mem_rdata <= '0;
			wait_cnt  <= 0;
			rd_count  <= 0;
			wb_count  <= 0;
			wb_addr   <= '0;
		end else begin
			mem_ready <= 1'b0;
			if ((mem_read || mem_write) && !mem_ready) begin
				if (wait_cnt == latency - 1) begin
					wait_cnt  <= 0;
					mem_ready <= 1'b1;    // one cycle only
					if (mem_write) begin
						store[mem_addr] = mem_wdata;
						wb_count <= wb_count + 1;
						wb_addr  <= mem_addr;
					end else begin
						if (store.exists(mem_addr)) begin
							mem_rdata <= store[mem_addr];
						end else begin
							mem_rdata <= fill_pattern(mem_addr);
						end
						rd_count  <= rd_count + 1;
					end
				end else begin
					wait_cnt <= wait_cnt + 1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
dcache_pkg.sv
dcache_array.sv
dcache_ctrl.sv
dcache_top.sv
tb_mem_model.sv
tb_dcache.sv
